//--- sim.f
+incdir+hdl
hdl/filter_cond_pkg.sv
hdl/packet_if.sv
hdl/packet_fifo.sv
hdl/filter_cond_control.sv
hdl/filter_cond_pipeline.sv
hdl/filter_cond_engine.sv
tb/filter_cond_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module filter_cond_engine_tb

result=$(./obj_dir/Vfilter_cond_engine_tb)
echo "$result"

if echo "$result" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

//--- tb/filter_cond_engine_tb.sv
// Self-checking testbench that runs a table of configurations through the filter/route engine
`timescale 1ns/100ps
`include "filter_cond_config.svh"

module filter_cond_engine_tb;

    typedef struct packed {
        filter_cond_pkg::fc_op_e op;
        logic [`FC_DATA_W-1:0]   operand;
        logic                    invert;
        logic                    conditional;
        logic [`FC_DEST_W-1:0]   route_if;
        logic [`FC_DEST_W-1:0]   route_else;
        logic [7:0]              count;
        logic [`FC_DATA_W-1:0]   base;
    } run_row_t;

    typedef struct packed {
        logic [`FC_DATA_W-1:0] data;
        logic [`FC_DEST_W-1:0] dest;
        logic [`FC_SEQ_W-1:0]  seq_id;
    } exp_pkt_t;

    // op, operand, invert, conditional, route_if, route_else, packets, data base
    localparam run_row_t RUNS [6] = '{
        '{filter_cond_pkg::OP_EQ, 32'd100, 1'b0, 1'b0, 4'd1, 4'd2, 8'd12, 32'd98},
        '{filter_cond_pkg::OP_NE, 32'd200, 1'b0, 1'b0, 4'd3, 4'd4, 8'd12, 32'd198},
        '{filter_cond_pkg::OP_LT, 32'd300, 1'b0, 1'b0, 4'd5, 4'd6, 8'd12, 32'd298},
        '{filter_cond_pkg::OP_LT, 32'd300, 1'b1, 1'b0, 4'd5, 4'd6, 8'd12, 32'd298},
        '{filter_cond_pkg::OP_GT, 32'd400, 1'b1, 1'b0, 4'd7, 4'd8, 8'd12, 32'd398},
        '{filter_cond_pkg::OP_GT, 32'h1000, 1'b0, 1'b1, 4'd9, 4'd10, 8'd40, 32'hffe}
    };
    // Long conditional run gets a forced output stall
    localparam int LONG_RUN     = 5;
    localparam int STALL_CYCLES = 80;

    logic                  ap_clk = 1'b0;
    logic                  areset_generator = 1'b1;
    logic                  cfg_valid = 1'b0;
    logic                  cfg_invert = 1'b0;
    logic                  cfg_conditional = 1'b0;
    logic [1:0]            cfg_op = 2'd0;
    logic [`FC_DATA_W-1:0] cfg_operand = '0;
    logic [`FC_DATA_W-1:0] in_data = '0;
    logic [`FC_DEST_W-1:0] cfg_route_if = '0;
    logic [`FC_DEST_W-1:0] cfg_route_else = '0;
    logic [`FC_DEST_W-1:0] in_dest = '0;
    logic [`FC_SEQ_W-1:0]  in_seq_id = '0;
    logic                  in_valid = 1'b0;
    logic                  in_last = 1'b0;
    logic                  out_ready = 1'b0;
    logic                  cfg_ready;
    logic                  in_ready;
    logic                  out_valid;
    logic                  done;
    logic [`FC_DATA_W-1:0] out_data;
    logic [`FC_DEST_W-1:0] out_dest;
    logic [`FC_SEQ_W-1:0]  out_seq_id;

    exp_pkt_t exp_q [$];
    exp_pkt_t head;
    int       cycles = 0;
    int       stall_until = 0;
    int       in_stalls = 0;
    int       checked = 0;
    int       monitor_errors = 0;
    int       flow_errors = 0;

    filter_cond_engine DUT (.*);

    initial begin
        forever #10 ap_clk = ~ap_clk;
    end

    // Random back-pressure that is held low inside the stall window
    always @(posedge ap_clk) begin
        cycles <= cycles + 1;
        if (areset_generator || cycles < stall_until) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= ($urandom % 4) != 0;
        end
    end

    // Single-bit status output against its expected level
    task automatic compare_flag(input string name, input logic actual, input logic expected);
        assert (actual == expected) else begin
            flow_errors++;
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // Every forwarded packet of a run has left the engine
    task automatic verify_drained(input int run_idx);
        assert (exp_q.size() == 0) else begin
            flow_errors++;
            $display("Run %0d finished with %0d expected packets unseen", run_idx, exp_q.size());
        end
    endtask

    // ------------------------------
    // Output monitor
    // ------------------------------
    always @(posedge ap_clk) begin
        if (!areset_generator) begin
            if (in_valid && !in_ready && cycles < stall_until) begin
                in_stalls++;
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() > 0) else begin
                    monitor_errors++;
                    $display("Unexpected output packet, seq_id %0d at %0t", out_seq_id, $time);
                end
                if (exp_q.size() > 0) begin
                    head = exp_q.pop_front();
                    checked++;
                    assert (out_data == head.data) else begin
                        monitor_errors++;
                        $display("Mismatch at %0t: out_data = %h, expected %h",
                                 $time, out_data, head.data);
                    end
                    assert (out_dest == head.dest) else begin
                        monitor_errors++;
                        $display("Mismatch at %0t: out_dest = %0d, expected %0d",
                                 $time, out_dest, head.dest);
                    end
                    assert (out_seq_id == head.seq_id) else begin
                        monitor_errors++;
                        $display("Mismatch at %0t: out_seq_id = %0d, expected %0d",
                                 $time, out_seq_id, head.seq_id);
                    end
                end
            end
        end
    end

    // ------------------------------
    // Stimulus and expected packets
    // ------------------------------
    initial begin
        exp_pkt_t              exp;
        logic [`FC_DATA_W-1:0] data;
        logic [`FC_DATA_W-1:0] prev_data [256];
        logic [`FC_DEST_W-1:0] dest;
        logic [`FC_SEQ_W-1:0]  seq;
        logic [31:0]           rnd;
        logic                  hit;
        logic                  reuse;
        void'($urandom(94604));
        seq = '0;
        repeat (2) @(posedge ap_clk);
        areset_generator <= 1'b0;
        @(posedge ap_clk);
        // Controller still in its reset state
        compare_flag("cfg_ready", cfg_ready, 1'b0);
        compare_flag("in_ready", in_ready, 1'b0);
        compare_flag("out_valid", out_valid, 1'b0);
        @(posedge ap_clk);
        compare_flag("done", done, 1'b1);
        compare_flag("cfg_ready", cfg_ready, 1'b1);
        for (int r = 0; r < 6; r++) begin
            cfg_valid       <= 1'b1;
            cfg_op          <= RUNS[r].op;
            cfg_operand     <= RUNS[r].operand;
            cfg_invert      <= RUNS[r].invert;
            cfg_conditional <= RUNS[r].conditional;
            cfg_route_if    <= RUNS[r].route_if;
            cfg_route_else  <= RUNS[r].route_else;
            do @(posedge ap_clk); while (!cfg_ready);
            // Accepted only once the previous run has fully left
            compare_flag("done", done, 1'b1);
            verify_drained(r - 1);
            cfg_valid <= 1'b0;
            @(posedge ap_clk);
            compare_flag("done", done, 1'b0);
            compare_flag("cfg_ready", cfg_ready, 1'b0);
            if (r == LONG_RUN) stall_until <= cycles + STALL_CYCLES;
            // Same compare as the row before replays its data
            reuse = (r > 0) && (RUNS[r].op == RUNS[r-1].op)
                    && (RUNS[r].operand == RUNS[r-1].operand);
            for (int i = 0; i < int'(RUNS[r].count); i++) begin
                if (reuse) begin
                    data = prev_data[i];
                end else begin
                    rnd  = $urandom;
                    data = RUNS[r].base + (rnd % 4);
                end
                prev_data[i] = data;
                rnd  = $urandom;
                dest = rnd[`FC_DEST_W-1:0];
                // Unsigned compare followed by invert
                case (RUNS[r].op)
                    filter_cond_pkg::OP_EQ: hit = (data == RUNS[r].operand);
                    filter_cond_pkg::OP_NE: hit = (data != RUNS[r].operand);
                    filter_cond_pkg::OP_LT: hit = (data < RUNS[r].operand);
                    default:                hit = (data > RUNS[r].operand);
                endcase
                hit = hit ^ RUNS[r].invert;
                if (RUNS[r].conditional || hit) begin
                    exp.data   = data;
                    exp.dest   = dest;
                    exp.seq_id = seq;
                    if (RUNS[r].conditional) begin
                        exp.dest = hit ? RUNS[r].route_if : RUNS[r].route_else;
                    end
                    exp_q.push_back(exp);
                end
                in_valid  <= 1'b1;
                in_data   <= data;
                in_dest   <= dest;
                in_seq_id <= seq;
                in_last   <= (i == int'(RUNS[r].count) - 1);
                do @(posedge ap_clk); while (!in_ready);
                seq++;
            end
            in_valid <= 1'b0;
        end
        while (!done) @(posedge ap_clk);
        verify_drained(5);
        assert (in_stalls > 0) else begin
            flow_errors++;
            $display("in_ready never fell while the output was stalled");
        end
        $display("Checked %0d packets: %0d output errors, %0d flow errors",
                 checked, monitor_errors, flow_errors);
        if (monitor_errors == 0 && flow_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the packet count of the table
    initial begin
        int limit;
        limit = 100;
        for (int r = 0; r < 6; r++) begin
            limit += 200 * int'(RUNS[r].count);
        end
        repeat (limit) @(posedge ap_clk);
        $display("Timeout: runs did not finish within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- hdl/filter_cond_engine.sv
// Top level of the filter/route engine with plain valid/ready ports for configuration and packets
`timescale 1ns/100ps
`include "filter_cond_config.svh"

module filter_cond_engine (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    // Configuration
    input  logic                  cfg_valid,
    output logic                  cfg_ready,
    input  logic [1:0]            cfg_op,
    input  logic [`FC_DATA_W-1:0] cfg_operand,
    input  logic                  cfg_invert,
    input  logic                  cfg_conditional,
    input  logic [`FC_DEST_W-1:0] cfg_route_if,
    input  logic [`FC_DEST_W-1:0] cfg_route_else,
    // Input stream
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [`FC_DATA_W-1:0] in_data,
    input  logic [`FC_DEST_W-1:0] in_dest,
    input  logic [`FC_SEQ_W-1:0]  in_seq_id,
    input  logic                  in_last,
    // Output stream
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [`FC_DATA_W-1:0] out_data,
    output logic [`FC_DEST_W-1:0] out_dest,
    output logic [`FC_SEQ_W-1:0]  out_seq_id,
    output logic                  done
);

    filter_cond_pkg::filter_cond_cfg_t cfg_in;
    filter_cond_pkg::filter_cond_cfg_t cfg;

    logic run;
    logic out_almost_full;
    logic out_empty;
    logic last_taken;
    logic pipe_idle;

    packet_if in_push ();
    packet_if in_pop ();
    packet_if out_push ();
    packet_if out_pop ();

    // Port packing
    assign cfg_in = '{op: filter_cond_pkg::fc_op_e'(cfg_op), operand: cfg_operand,
                      invert: cfg_invert, conditional: cfg_conditional,
                      route_if: cfg_route_if, route_else: cfg_route_else};

    assign in_push.valid = in_valid;
    assign in_push.pkt   = '{data: in_data, dest: in_dest, seq_id: in_seq_id, last: in_last};
    assign in_ready      = in_push.ready;

    assign out_valid     = out_pop.valid;
    assign out_pop.ready = out_ready;
    assign out_data      = out_pop.pkt.data;
    assign out_dest      = out_pop.pkt.dest;
    assign out_seq_id    = out_pop.pkt.seq_id;

    packet_fifo in_fifo (.ap_clk(ap_clk), .areset_generator(areset_generator),
        .push(in_push), .pop(in_pop), .almost_full(), .empty());

    packet_fifo out_fifo (.ap_clk(ap_clk), .areset_generator(areset_generator),
        .push(out_push), .pop(out_pop), .almost_full(out_almost_full), .empty(out_empty));

    filter_cond_control u_control (.ap_clk(ap_clk), .areset_generator(areset_generator),
        .cfg_valid(cfg_valid), .cfg_ready(cfg_ready), .cfg_in(cfg_in), .cfg(cfg),
        .run(run), .almost_full(out_almost_full), .last_taken(last_taken),
        .pipe_idle(pipe_idle), .out_empty(out_empty), .done(done));

    filter_cond_pipeline u_pipeline (.ap_clk(ap_clk), .areset_generator(areset_generator),
        .cfg(cfg), .run(run), .in_pkt(in_pop), .out_pkt(out_push),
        .last_taken(last_taken), .pipe_idle(pipe_idle));

endmodule

//--- hdl/filter_cond_pipeline.sv
// Three-stage compare, filter and route pipeline between the input and output FIFOs
`timescale 1ns/100ps
`include "filter_cond_config.svh"

module filter_cond_pipeline (
    input  logic                               ap_clk,
    input  logic                               areset_generator,
    input  filter_cond_pkg::filter_cond_cfg_t  cfg,
    input  logic                               run,
    packet_if.snk                              in_pkt,
    packet_if.src                              out_pkt,
    output logic                               last_taken,
    output logic                               pipe_idle
);

    filter_cond_pkg::engine_packet_t s1_pkt;
    filter_cond_pkg::engine_packet_t s2_pkt;
    filter_cond_pkg::engine_packet_t s3_pkt;

    logic                  s1_valid;
    logic                  s2_valid;
    logic                  s3_valid;
    logic                  take;
    logic                  cmp_true;
    logic                  s2_hit;
    logic                  forward;
    logic [`FC_DEST_W-1:0] route;

    // Pop side
    assign in_pkt.ready = run;
    assign take         = in_pkt.valid & run;
    assign last_taken   = take & in_pkt.pkt.last;

    assign pipe_idle = ~(s1_valid | s2_valid | s3_valid);

    // The almost-full margin keeps room in out_fifo for every push
    assign out_pkt.valid = s3_valid;
    assign out_pkt.pkt   = s3_pkt;

    // ------------------------------
    // Stage 2 compare
    // ------------------------------
    always_comb begin
        case (cfg.op)
            filter_cond_pkg::OP_EQ: cmp_true = (s1_pkt.data == cfg.operand);
            filter_cond_pkg::OP_NE: cmp_true = (s1_pkt.data != cfg.operand);
            filter_cond_pkg::OP_LT: cmp_true = (s1_pkt.data < cfg.operand);
            filter_cond_pkg::OP_GT: cmp_true = (s1_pkt.data > cfg.operand);
            default:                cmp_true = 1'b0;
        endcase
    end

    // ------------------------------
    // Stage 3 filter and route
    // ------------------------------
    // Conditional mode keeps every packet
    assign forward = cfg.conditional | s2_hit;

    always_comb begin
        if (cfg.conditional) begin
            route = s2_hit ? cfg.route_if : cfg.route_else;
        end else begin
            route = s2_pkt.dest;
        end
    end

    // Stage valids
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= take;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid & forward;
        end
    end

    // Payload
    always_ff @(posedge ap_clk) begin
        s1_pkt <= in_pkt.pkt;
        s2_pkt <= s1_pkt;
        s2_hit <= cmp_true ^ cfg.invert;

        s3_pkt.data   <= s2_pkt.data;
        s3_pkt.dest   <= route;
        s3_pkt.seq_id <= s2_pkt.seq_id;
        s3_pkt.last   <= s2_pkt.last;
    end

endmodule

//--- hdl/filter_cond_control.sv
// Run controller that latches the configuration, throttles the pipeline and reports done
`timescale 1ns/100ps

module filter_cond_control (
    input  logic                               ap_clk,
    input  logic                               areset_generator,
    input  logic                               cfg_valid,
    output logic                               cfg_ready,
    input  filter_cond_pkg::filter_cond_cfg_t  cfg_in,
    output filter_cond_pkg::filter_cond_cfg_t  cfg,
    output logic                               run,
    input  logic                               almost_full,
    input  logic                               last_taken,
    input  logic                               pipe_idle,
    input  logic                               out_empty,
    output logic                               done
);

    filter_cond_pkg::fc_state_e state;
    filter_cond_pkg::fc_state_e state_next;
    logic                       cfg_take;

    assign cfg_ready = (state == filter_cond_pkg::ST_IDLE);
    assign done      = (state == filter_cond_pkg::ST_IDLE);
    assign cfg_take  = cfg_valid & cfg_ready;

    // Pops stop in the same cycle out_fifo turns almost full
    assign run = (state == filter_cond_pkg::ST_BUSY) & ~almost_full;

    always_comb begin
        state_next = state;
        case (state)
            filter_cond_pkg::ST_RESET: state_next = filter_cond_pkg::ST_IDLE;
            filter_cond_pkg::ST_IDLE: begin
                if (cfg_take) state_next = filter_cond_pkg::ST_BUSY;
            end
            filter_cond_pkg::ST_BUSY: begin
                // A last packet can only be popped while almost_full is low
                if (last_taken) state_next = filter_cond_pkg::ST_DRAIN;
                else if (almost_full) state_next = filter_cond_pkg::ST_PAUSE;
            end
            filter_cond_pkg::ST_PAUSE: begin
                if (!almost_full) state_next = filter_cond_pkg::ST_BUSY;
            end
            filter_cond_pkg::ST_DRAIN: begin
                if (pipe_idle && out_empty) state_next = filter_cond_pkg::ST_IDLE;
            end
            default: state_next = filter_cond_pkg::ST_RESET;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= filter_cond_pkg::ST_RESET;
        end else begin
            state <= state_next;
        end
    end

    // Configuration held for the whole run
    always_ff @(posedge ap_clk) begin
        if (cfg_take) begin
            cfg <= cfg_in;
        end
    end

endmodule

//--- hdl/packet_fifo.sv
// First-word-fall-through packet FIFO that the engine instantiates at its input and output
`timescale 1ns/100ps
`include "filter_cond_config.svh"

module packet_fifo (
    input  logic  ap_clk,
    input  logic  areset_generator,
    packet_if.snk push,
    packet_if.src pop,
    output logic  almost_full,
    output logic  empty
);

    localparam int DEPTH = `FC_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    filter_cond_pkg::engine_packet_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic [CNT_W-1:0] free_slots;
    logic             push_ready;
    logic             do_push;
    logic             do_pop;

    assign do_push    = push.valid & push_ready;
    assign do_pop     = pop.valid & pop.ready;
    assign push.ready = push_ready;

    // Head entry is always visible
    assign pop.valid = (count != '0);
    assign pop.pkt   = mem[rd_ptr];

    assign empty       = (count == '0);
    assign free_slots  = CNT_W'(DEPTH) - count;
    assign almost_full = (free_slots < CNT_W'(`FC_ALMOST_MARGIN));

    always_comb begin
        case ({do_push, do_pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            push_ready <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // Low out of reset until space is known
            push_ready <= (count_next != CNT_W'(DEPTH));
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push.pkt;
        end
    end

endmodule

//--- hdl/packet_if.sv
// One valid/ready packet stream between engine blocks with source and sink views
`timescale 1ns/100ps

interface packet_if;

    // Transfer when valid and ready are both high at the edge
    logic                            valid;
    logic                            ready;
    filter_cond_pkg::engine_packet_t pkt;

    // Producer side
    modport src (
        output valid,
        output pkt,
        input  ready
    );

    // Consumer side
    modport snk (
        input  valid,
        input  pkt,
        output ready
    );

endinterface

//--- hdl/filter_cond_pkg.sv
// Opcode, state, packet and configuration types shared across the filter/route engine
`include "filter_cond_config.svh"

package filter_cond_pkg;

    // Unsigned compare opcodes
    typedef enum logic [1:0] {
        OP_EQ = 2'd0,
        OP_NE = 2'd1,
        OP_LT = 2'd2,
        OP_GT = 2'd3
    } fc_op_e;

    // Run controller states
    typedef enum logic [2:0] {
        ST_RESET = 3'd0,
        ST_IDLE  = 3'd1,
        ST_BUSY  = 3'd2,
        ST_PAUSE = 3'd3,
        ST_DRAIN = 3'd4
    } fc_state_e;

    typedef struct packed {
        logic [`FC_DATA_W-1:0] data;
        logic [`FC_DEST_W-1:0] dest;
        logic [`FC_SEQ_W-1:0]  seq_id;
        logic                  last;
    } engine_packet_t;

    // Latched once per run
    typedef struct packed {
        fc_op_e                op;
        logic [`FC_DATA_W-1:0] operand;
        logic                  invert;
        logic                  conditional;
        logic [`FC_DEST_W-1:0] route_if;
        logic [`FC_DEST_W-1:0] route_else;
    } filter_cond_cfg_t;

endpackage

//--- hdl/filter_cond_config.svh
// Width, depth and margin macros for the filter/route engine that RTL and testbench include
`ifndef FILTER_COND_CONFIG_SVH
`define FILTER_COND_CONFIG_SVH

// Packet field widths
`define FC_DATA_W 32
`define FC_DEST_W 4
`define FC_SEQ_W 8

// ------------------------------
// Buffering
// ------------------------------
`define FC_FIFO_DEPTH 16

// Free entries below which a FIFO reports almost full
// Must be at least the pipeline depth plus one
`define FC_ALMOST_MARGIN 4

`endif
